//--- rtl/ucode_pkg.sv
`default_nettype none

package ucode_pkg;

    // address split: category in the upper bits, step below
    localparam int OPCAT_AW = 5;
    localparam int STEP_AW  = 4;
    localparam int UCODE_AW = OPCAT_AW + STEP_AW;
    localparam int UCODE_DW = 18;

    typedef logic [OPCAT_AW-1:0] opcat_t;
    typedef logic [UCODE_AW-1:0] uaddr_t;
    typedef logic [UCODE_DW-1:0] uword_t;
    typedef logic [7:0]          opcode_t;

    // common routines
    localparam opcat_t RESET_CAT      = 5'd0;
    localparam opcat_t NMI_CAT        = 5'd1;
    localparam opcat_t FIRQ_CAT       = 5'd2;
    localparam opcat_t IRQ_CAT        = 5'd3;
    localparam opcat_t BUSERROR       = 5'd4;
    // opcode routines
    localparam opcat_t SINGLE_ALU     = 5'd5;
    localparam opcat_t SBRANCH        = 5'd6;
    localparam opcat_t NOPE           = 5'd7;
    localparam opcat_t PSH            = 5'd8;
    localparam opcat_t PARSE_IDX      = 5'd9;
    localparam opcat_t IDX_R          = 5'd10;
    localparam opcat_t IDX_RINC       = 5'd11;
    localparam opcat_t IDX_OFFSET8    = 5'd12;
    localparam opcat_t IDX_EXT        = 5'd13;
    localparam opcat_t IDX_IND        = 5'd14;
    localparam opcat_t SINGLE_ALU_IDX = 5'd15;  // follow-ups after indexed parsing
    localparam opcat_t STORE8         = 5'd16;
    localparam opcat_t JUMP           = 5'd17;

    localparam opcode_t SUBA_IMM = 8'h80;
    localparam opcode_t ANDA_IMM = 8'h84;
    localparam opcode_t LDA_IMM  = 8'h86;
    localparam opcode_t ADDA_IMM = 8'h8b;
    localparam opcode_t LDB_IMM  = 8'hc6;
    localparam opcode_t BRA      = 8'h20;
    localparam opcode_t BCS      = 8'h25;
    localparam opcode_t BNE      = 8'h26;
    localparam opcode_t BEQ      = 8'h27;
    localparam opcode_t NOP      = 8'h12;
    localparam opcode_t PUSHS    = 8'h34;
    localparam opcode_t PUSHU    = 8'h36;
    localparam opcode_t ANDA_IDX = 8'ha4;
    localparam opcode_t LDA_IDX  = 8'ha6;
    localparam opcode_t ADDA_IDX = 8'hab;
    localparam opcode_t LDB_IDX  = 8'he6;
    localparam opcode_t STA      = 8'ha7;
    localparam opcode_t STB      = 8'he7;
    localparam opcode_t JMP      = 8'h6e;

    // control word bit positions
    localparam int B_NI             = 0;
    localparam int B_OPD            = 1;
    localparam int B_UP_LD8         = 2;
    localparam int B_WE             = 3;
    localparam int B_MEMHI          = 4;
    localparam int B_SET_PC_BRANCH8 = 5;
    localparam int B_PC_JMP         = 6;
    localparam int B_PSH_GO         = 7;
    localparam int B_PSH_PC         = 8;
    localparam int B_PSH_CC         = 9;
    localparam int B_SET_I          = 10;
    localparam int B_SET_F          = 11;
    localparam int B_INT_EN         = 12;
    localparam int B_IDX_JMP        = 13;
    localparam int B_IDX_IND        = 14;
    localparam int B_IDX_RET        = 15;
    localparam int B_DATA2ADDR      = 16;
    localparam int B_BUSERROR       = 17;

    localparam int CC_I = 4;  // irq mask
    localparam int CC_F = 6;  // firq mask

endpackage

`default_nettype wire

//--- rtl/op_category.sv
`default_nettype none

module op_category (
    input  wire ucode_pkg::opcode_t op,
    input  wire ucode_pkg::opcat_t  post_idx,
    output ucode_pkg::opcat_t       opcat,
    output ucode_pkg::opcat_t       nx_cat
);

    always_comb begin
        nx_cat = post_idx;  // keep the follow-up while the postbyte is parsed
        case (op)
            ucode_pkg::LDA_IMM, ucode_pkg::ADDA_IMM, ucode_pkg::ANDA_IMM,
            ucode_pkg::SUBA_IMM, ucode_pkg::LDB_IMM: begin
                opcat = ucode_pkg::SINGLE_ALU;
            end
            ucode_pkg::BRA, ucode_pkg::BNE, ucode_pkg::BEQ, ucode_pkg::BCS: begin
                opcat = ucode_pkg::SBRANCH;
            end
            ucode_pkg::NOP: begin
                opcat = ucode_pkg::NOPE;
            end
            ucode_pkg::PUSHS, ucode_pkg::PUSHU: begin
                opcat = ucode_pkg::PSH;
            end
            // operand comes through an indexed address
            ucode_pkg::LDA_IDX, ucode_pkg::ADDA_IDX, ucode_pkg::ANDA_IDX,
            ucode_pkg::LDB_IDX: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::SINGLE_ALU_IDX;
            end
            ucode_pkg::STA, ucode_pkg::STB: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::STORE8;
            end
            ucode_pkg::JMP: begin
                opcat  = ucode_pkg::PARSE_IDX;
                nx_cat = ucode_pkg::JUMP;
            end
            default: begin
                opcat = ucode_pkg::BUSERROR;  // unknown opcode stops the core
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/idx_mode_decode.sv
`default_nettype none

module idx_mode_decode (
    input  wire [7:0]         mdata,
    output ucode_pkg::opcat_t idx_cat
);

    // bit 7 plus the low mode bits select the addressing routine
    always_comb begin
        case ({mdata[7], mdata[2:0]})
            4'b0_110: idx_cat = ucode_pkg::IDX_R;
            4'b0_000: idx_cat = ucode_pkg::IDX_RINC;
            4'b0_100: idx_cat = ucode_pkg::IDX_OFFSET8;
            4'b0_111: idx_cat = ucode_pkg::IDX_EXT;  // 16-bit address follows
            default:  idx_cat = ucode_pkg::BUSERROR;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/int_arbiter.sv
`default_nettype none

module int_arbiter (
    input  wire               clk,
    input  wire               rst,
    input  wire               cen,
    input  wire               nmi_n,
    input  wire               firq_n,
    input  wire               irq_n,
    input  wire [7:0]         cc,
    input  wire               nil,
    input  wire               int_en,
    output logic              take_int,
    output ucode_pkg::opcat_t int_cat,
    output logic [3:0]        intvec,
    output logic              intsrv
);

    logic       nmin_l;
    logic       do_nmi;
    logic       firq_rq;
    logic       irq_rq;
    logic [3:0] cur_int;
    logic [3:0] nx_int;

    assign firq_rq  = ~firq_n & ~cc[ucode_pkg::CC_F];  // level, masked by F
    assign irq_rq   = ~irq_n & ~cc[ucode_pkg::CC_I];
    assign intsrv   = do_nmi | firq_rq | irq_rq;
    assign take_int = intsrv;
    assign intvec   = int_en ? cur_int : 4'b0000;

    always_comb begin
        if (do_nmi) begin
            int_cat = ucode_pkg::NMI_CAT;
            nx_int  = 4'b0100;
        end else if (firq_rq) begin
            int_cat = ucode_pkg::FIRQ_CAT;
            nx_int  = 4'b0010;
        end else if (irq_rq) begin
            int_cat = ucode_pkg::IRQ_CAT;
            nx_int  = 4'b0001;
        end else begin
            int_cat = ucode_pkg::NOPE;  // ignored by the sequencer
            nx_int  = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            nmin_l  <= 1'b0;
            do_nmi  <= 1'b0;
            cur_int <= 4'b1000;  // reset vector
        end else if (cen) begin
            nmin_l <= nmi_n;
            if (nil) begin
                cur_int <= nx_int;
                do_nmi  <= 1'b0;  // serviced at dispatch
            end
            if (nmin_l && !nmi_n) do_nmi <= 1'b1;  // falling edge wins over service
        end
    end

endmodule

`default_nettype wire

//--- rtl/ucode_rom.sv
`default_nettype none

module ucode_rom (
    input  wire ucode_pkg::uaddr_t uaddr,
    output ucode_pkg::uword_t      uword
);

    function automatic ucode_pkg::uaddr_t at(ucode_pkg::opcat_t cat, int step);
        logic [ucode_pkg::STEP_AW-1:0] s;
        s = step[ucode_pkg::STEP_AW-1:0];
        return {cat, s};
    endfunction

    function automatic ucode_pkg::uword_t cw(int pos);
        ucode_pkg::uword_t w;
        w      = '0;
        w[pos] = 1'b1;
        return w;
    endfunction

    always_comb begin
        case (uaddr)
            at(ucode_pkg::RESET_CAT, 0): uword = cw(ucode_pkg::B_SET_I) | cw(ucode_pkg::B_SET_F)
                                                | cw(ucode_pkg::B_INT_EN);
            at(ucode_pkg::RESET_CAT, 1): uword = cw(ucode_pkg::B_NI) | cw(ucode_pkg::B_INT_EN);
            // interrupt entry, the three sources share most steps
            at(ucode_pkg::NMI_CAT, 0), at(ucode_pkg::FIRQ_CAT, 0),
            at(ucode_pkg::IRQ_CAT, 0): uword = cw(ucode_pkg::B_PSH_PC);
            at(ucode_pkg::NMI_CAT, 1), at(ucode_pkg::FIRQ_CAT, 1),
            at(ucode_pkg::IRQ_CAT, 1): uword = cw(ucode_pkg::B_PSH_CC);
            at(ucode_pkg::NMI_CAT, 2),
            at(ucode_pkg::FIRQ_CAT, 2): uword = cw(ucode_pkg::B_SET_I) | cw(ucode_pkg::B_SET_F);
            at(ucode_pkg::IRQ_CAT, 2):  uword = cw(ucode_pkg::B_SET_I);
            at(ucode_pkg::NMI_CAT, 3), at(ucode_pkg::FIRQ_CAT, 3),
            at(ucode_pkg::IRQ_CAT, 3): uword = cw(ucode_pkg::B_INT_EN) | cw(ucode_pkg::B_PC_JMP);
            at(ucode_pkg::NMI_CAT, 4), at(ucode_pkg::FIRQ_CAT, 4),
            at(ucode_pkg::IRQ_CAT, 4): uword = cw(ucode_pkg::B_NI);
            at(ucode_pkg::BUSERROR, 0): uword = cw(ucode_pkg::B_BUSERROR);  // halts here
            at(ucode_pkg::SINGLE_ALU, 0): uword = cw(ucode_pkg::B_OPD) | cw(ucode_pkg::B_UP_LD8);
            at(ucode_pkg::SINGLE_ALU, 1): uword = cw(ucode_pkg::B_NI);
            at(ucode_pkg::SBRANCH, 0): uword = cw(ucode_pkg::B_OPD);
            at(ucode_pkg::SBRANCH, 1): uword = cw(ucode_pkg::B_SET_PC_BRANCH8)
                                              | cw(ucode_pkg::B_NI);
            at(ucode_pkg::NOPE, 0): uword = cw(ucode_pkg::B_NI);
            at(ucode_pkg::PSH, 0): uword = cw(ucode_pkg::B_PSH_GO);
            at(ucode_pkg::PSH, 1): uword = cw(ucode_pkg::B_PSH_PC);
            at(ucode_pkg::PSH, 2): uword = cw(ucode_pkg::B_PSH_CC);
            at(ucode_pkg::PSH, 3): uword = cw(ucode_pkg::B_NI);
            // postbyte parsing and address modes
            at(ucode_pkg::PARSE_IDX, 0): uword = cw(ucode_pkg::B_OPD) | cw(ucode_pkg::B_IDX_JMP);
            at(ucode_pkg::IDX_R, 0): uword = cw(ucode_pkg::B_IDX_IND);
            at(ucode_pkg::IDX_RINC, 0): uword = cw(ucode_pkg::B_IDX_IND);
            at(ucode_pkg::IDX_OFFSET8, 0): uword = cw(ucode_pkg::B_OPD);
            at(ucode_pkg::IDX_OFFSET8, 1): uword = cw(ucode_pkg::B_IDX_IND);
            at(ucode_pkg::IDX_EXT, 0): uword = cw(ucode_pkg::B_OPD) | cw(ucode_pkg::B_MEMHI);
            at(ucode_pkg::IDX_EXT, 1): uword = cw(ucode_pkg::B_OPD);
            at(ucode_pkg::IDX_EXT, 2): uword = cw(ucode_pkg::B_IDX_IND);
            at(ucode_pkg::IDX_IND, 0): uword = cw(ucode_pkg::B_MEMHI);  // pointer high byte
            at(ucode_pkg::IDX_IND, 1): uword = cw(ucode_pkg::B_IDX_RET);
            at(ucode_pkg::SINGLE_ALU_IDX, 0): uword = cw(ucode_pkg::B_UP_LD8)
                                                     | cw(ucode_pkg::B_DATA2ADDR);
            at(ucode_pkg::SINGLE_ALU_IDX, 1): uword = cw(ucode_pkg::B_NI);
            at(ucode_pkg::STORE8, 0): uword = cw(ucode_pkg::B_WE) | cw(ucode_pkg::B_DATA2ADDR);
            at(ucode_pkg::STORE8, 1): uword = cw(ucode_pkg::B_NI);
            at(ucode_pkg::JUMP, 0): uword = cw(ucode_pkg::B_PC_JMP) | cw(ucode_pkg::B_NI);
            default: uword = '0;  // idle, also the slot after every ni
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/ucode_seq.sv
`default_nettype none

module ucode_seq (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cen,
    input  wire                    mem_busy,
    input  wire                    ni,
    input  wire                    idx_jmp,
    input  wire                    idx_ind,
    input  wire                    idx_ret,
    input  wire                    buserror,
    input  wire ucode_pkg::opcat_t opcat,
    input  wire ucode_pkg::opcat_t nx_cat,
    input  wire ucode_pkg::opcat_t idx_cat,
    input  wire ucode_pkg::opcat_t int_cat,
    input  wire                    take_int,
    input  wire [7:0]              mdata,
    output ucode_pkg::uaddr_t      uaddr,
    output logic                   nil,
    output logic [2:0]             idx_rsel,
    output logic                   idx_ind_rq,
    output logic                   idx_post,
    output ucode_pkg::opcat_t      post_idx
);

    logic                          ni_l;
    logic                          run;
    ucode_pkg::opcat_t             dispatch_cat;

    // step 0 of a routine
    function automatic ucode_pkg::uaddr_t first_step(ucode_pkg::opcat_t cat);
        return {cat, {ucode_pkg::STEP_AW{1'b0}}};
    endfunction

    assign run          = cen & ~mem_busy & ~buserror;  // buserror halts until reset
    assign nil          = ni_l & ~mem_busy;  // dispatch happens on this cycle
    assign dispatch_cat = take_int ? int_cat : opcat;

    always_ff @(posedge clk) begin
        if (rst) begin
            uaddr      <= first_step(ucode_pkg::RESET_CAT);
            ni_l       <= 1'b0;
            post_idx   <= '0;
            idx_rsel   <= 3'd0;
            idx_ind_rq <= 1'b0;
            idx_post   <= 1'b0;
        end else if (cen) begin
            idx_post <= 1'b0;
            if (run) begin
                ni_l     <= ni;
                post_idx <= nx_cat;
                uaddr    <= uaddr + 1'b1;
                // idle slot after ni, pick the next routine
                if (nil) uaddr <= first_step(dispatch_cat);
                if (idx_jmp) begin
                    uaddr      <= first_step(idx_cat);
                    idx_rsel   <= mdata[6:4];
                    idx_ind_rq <= mdata[3];
                end
                if (idx_ind) begin
                    // indirect step only if the postbyte asked for it
                    uaddr    <= idx_ind_rq ? first_step(ucode_pkg::IDX_IND)
                                           : first_step(post_idx);
                    idx_post <= 1'b1;
                end
                if (idx_ret) begin
                    uaddr      <= first_step(post_idx);
                    idx_ind_rq <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ucode_top.sv
`default_nettype none

module ucode_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     cen,
    input  wire ucode_pkg::opcode_t op,
    input  wire [7:0]               mdata,
    input  wire [7:0]               cc,
    input  wire                     mem_busy,
    input  wire                     irq_n,
    input  wire                     firq_n,
    input  wire                     nmi_n,
    output wire                     ni,
    output wire                     opd,
    output wire                     up_ld8,
    output wire                     we,
    output wire                     memhi,
    output wire                     set_pc_branch8,
    output wire                     pc_jmp,
    output wire                     psh_go,
    output wire                     psh_pc,
    output wire                     psh_cc,
    output wire                     set_i,
    output wire                     set_f,
    output wire                     buserror,
    output wire [2:0]               idx_rsel,
    output wire                     idx_ind_rq,
    output wire                     idx_post,
    output wire [3:0]               intvec,
    output wire                     intsrv
);

    ucode_pkg::opcat_t opcat;
    ucode_pkg::opcat_t nx_cat;
    ucode_pkg::opcat_t post_idx;
    ucode_pkg::opcat_t idx_cat;
    ucode_pkg::opcat_t int_cat;
    ucode_pkg::uaddr_t uaddr;
    ucode_pkg::uword_t uword;
    wire               take_int;
    wire               nil;
    wire               int_en;
    wire               idx_jmp;
    wire               idx_ind;
    wire               idx_ret;

    // strobes straight from the control word
    assign ni             = uword[ucode_pkg::B_NI];
    assign opd            = uword[ucode_pkg::B_OPD];
    assign up_ld8         = uword[ucode_pkg::B_UP_LD8];
    assign we             = uword[ucode_pkg::B_WE];
    assign memhi          = uword[ucode_pkg::B_MEMHI];
    assign set_pc_branch8 = uword[ucode_pkg::B_SET_PC_BRANCH8];
    assign pc_jmp         = uword[ucode_pkg::B_PC_JMP];
    assign psh_go         = uword[ucode_pkg::B_PSH_GO];
    assign psh_pc         = uword[ucode_pkg::B_PSH_PC];
    assign psh_cc         = uword[ucode_pkg::B_PSH_CC];
    assign set_i          = uword[ucode_pkg::B_SET_I];
    assign set_f          = uword[ucode_pkg::B_SET_F];
    assign buserror       = uword[ucode_pkg::B_BUSERROR];
    assign int_en         = uword[ucode_pkg::B_INT_EN];  // internal, gates intvec
    assign idx_jmp        = uword[ucode_pkg::B_IDX_JMP];
    assign idx_ind        = uword[ucode_pkg::B_IDX_IND];
    assign idx_ret        = uword[ucode_pkg::B_IDX_RET];

    op_category u_op_category (
        .op       (op),
        .post_idx (post_idx),
        .opcat    (opcat),
        .nx_cat   (nx_cat)
    );

    idx_mode_decode u_idx_mode_decode (
        .mdata   (mdata),
        .idx_cat (idx_cat)
    );

    int_arbiter u_int_arbiter (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .nmi_n    (nmi_n),
        .firq_n   (firq_n),
        .irq_n    (irq_n),
        .cc       (cc),
        .nil      (nil),
        .int_en   (int_en),
        .take_int (take_int),
        .int_cat  (int_cat),
        .intvec   (intvec),
        .intsrv   (intsrv)
    );

    ucode_seq u_ucode_seq (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .ni         (ni),
        .idx_jmp    (idx_jmp),
        .idx_ind    (idx_ind),
        .idx_ret    (idx_ret),
        .buserror   (buserror),
        .opcat      (opcat),
        .nx_cat     (nx_cat),
        .idx_cat    (idx_cat),
        .int_cat    (int_cat),
        .take_int   (take_int),
        .mdata      (mdata),
        .uaddr      (uaddr),
        .nil        (nil),
        .idx_rsel   (idx_rsel),
        .idx_ind_rq (idx_ind_rq),
        .idx_post   (idx_post),
        .post_idx   (post_idx)
    );

    ucode_rom u_ucode_rom (
        .uaddr (uaddr),
        .uword (uword)
    );

endmodule

`default_nettype wire

//--- testbench/tb_ucode.sv
`default_nettype none

module tb_ucode;

    // observed word: {intvec, idx_post, buserror, set_f, set_i, psh_cc, psh_pc, psh_go,
    //                 pc_jmp, set_pc_branch8, memhi, we, up_ld8, opd, ni}
    localparam logic [17:0] K_NI   = 18'h00001;
    localparam logic [17:0] K_OPD  = 18'h00002;
    localparam logic [17:0] K_UP   = 18'h00004;
    localparam logic [17:0] K_WE   = 18'h00008;
    localparam logic [17:0] K_MEM  = 18'h00010;
    localparam logic [17:0] K_BR   = 18'h00020;
    localparam logic [17:0] K_JMP  = 18'h00040;
    localparam logic [17:0] K_GO   = 18'h00080;
    localparam logic [17:0] K_PC   = 18'h00100;
    localparam logic [17:0] K_CC   = 18'h00200;
    localparam logic [17:0] K_I    = 18'h00400;
    localparam logic [17:0] K_F    = 18'h00800;
    localparam logic [17:0] K_ERR  = 18'h01000;
    localparam logic [17:0] K_POST = 18'h02000;
    localparam logic [17:0] V_IRQ  = 18'h04000;  // intvec 0001
    localparam logic [17:0] V_FIRQ = 18'h08000;
    localparam logic [17:0] V_NMI  = 18'h10000;
    localparam logic [17:0] V_RST  = 18'h20000;  // intvec 1000

    logic clk, rst, cen, mem_busy, irq_n, firq_n, nmi_n;
    logic [7:0] op, mdata, cc;
    wire ni, opd, up_ld8, we, memhi, set_pc_branch8, pc_jmp;
    wire psh_go, psh_pc, psh_cc, set_i, set_f, buserror;
    wire [2:0] idx_rsel;
    wire idx_ind_rq, idx_post, intsrv;
    wire [3:0] intvec;

    // stimulus table
    bit          e_reset[0:31];  // entry starts with a reset
    bit          e_idx[0:31];
    logic [7:0]  e_op[0:31];
    logic [7:0]  e_md[0:31];
    logic        e_nmi[0:31];
    logic        e_firq[0:31];
    logic        e_irq[0:31];
    logic [7:0]  e_cc[0:31];
    int          e_first[0:31];
    int          e_len[0:31];
    logic [17:0] exp_w[0:255];
    int          n_ent = 0;
    int          n_w = 0;
    int          errors = 0;
    int          cycles = 0;
    int          limit = 0;
    int          seed_val;

    ucode_top DUT (
        .clk(clk), .rst(rst), .cen(cen), .op(op), .mdata(mdata), .cc(cc),
        .mem_busy(mem_busy), .irq_n(irq_n), .firq_n(firq_n), .nmi_n(nmi_n),
        .ni(ni), .opd(opd), .up_ld8(up_ld8), .we(we), .memhi(memhi),
        .set_pc_branch8(set_pc_branch8), .pc_jmp(pc_jmp), .psh_go(psh_go),
        .psh_pc(psh_pc), .psh_cc(psh_cc), .set_i(set_i), .set_f(set_f),
        .buserror(buserror), .idx_rsel(idx_rsel), .idx_ind_rq(idx_ind_rq),
        .idx_post(idx_post), .intvec(intvec), .intsrv(intsrv)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input logic [17:0] got, input logic [17:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [17:0] observed();
        return {intvec, idx_post, buserror, set_f, set_i, psh_cc, psh_pc, psh_go,
                pc_jmp, set_pc_branch8, memhi, we, up_ld8, opd, ni};
    endfunction

    task automatic new_entry(input bit rs, input bit ix, input logic [7:0] o,
                             input logic [7:0] md, input logic nm, input logic fq,
                             input logic iq, input logic [7:0] c);
        e_reset[n_ent] = rs;
        e_idx[n_ent]   = ix;
        e_op[n_ent]    = o;
        e_md[n_ent]    = md;
        e_nmi[n_ent]   = nm;
        e_firq[n_ent]  = fq;
        e_irq[n_ent]   = iq;
        e_cc[n_ent]    = c;
        e_first[n_ent] = n_w;
        e_len[n_ent]   = 0;
        n_ent++;
    endtask

    task automatic add_word(input logic [17:0] x);
        exp_w[n_w] = x;
        n_w++;
        e_len[n_ent-1]++;
    endtask

    task automatic add_halt();
        repeat (6) add_word(K_ERR);  // frozen until reset
    endtask

    task automatic build_table();
        new_entry(1, 0, ucode_pkg::NOP, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_I | K_F | V_RST); add_word(K_NI | V_RST);
        new_entry(0, 0, ucode_pkg::LDA_IMM, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_OPD | K_UP); add_word(K_NI);
        new_entry(0, 0, ucode_pkg::BRA, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(K_BR | K_NI);
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_NI);
        new_entry(0, 0, ucode_pkg::PUSHS, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_GO); add_word(K_PC); add_word(K_CC); add_word(K_NI);
        // indexed modes, plain then indirect
        new_entry(0, 1, ucode_pkg::LDA_IDX, 8'h16, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(0); add_word(K_UP | K_POST); add_word(K_NI);
        new_entry(0, 1, ucode_pkg::LDA_IDX, 8'h1e, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(0); add_word(K_MEM | K_POST); add_word(0);
        add_word(K_UP); add_word(K_NI);
        new_entry(0, 1, ucode_pkg::STA, 8'h20, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(0); add_word(K_WE | K_POST); add_word(K_NI);
        new_entry(0, 1, ucode_pkg::STA, 8'h28, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(0); add_word(K_MEM | K_POST); add_word(0);
        add_word(K_WE); add_word(K_NI);
        new_entry(0, 1, ucode_pkg::JMP, 8'h34, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(K_OPD); add_word(0); add_word(K_JMP | K_NI | K_POST);
        new_entry(0, 1, ucode_pkg::JMP, 8'h3c, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(K_OPD); add_word(0); add_word(K_MEM | K_POST);
        add_word(0); add_word(K_JMP | K_NI);
        new_entry(0, 1, ucode_pkg::LDA_IDX, 8'h47, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(K_OPD | K_MEM); add_word(K_OPD); add_word(0);
        add_word(K_UP | K_POST); add_word(K_NI);
        new_entry(0, 1, ucode_pkg::STA, 8'h5f, 1, 1, 1, 8'h00);
        add_word(K_OPD); add_word(K_OPD | K_MEM); add_word(K_OPD); add_word(0);
        add_word(K_MEM | K_POST); add_word(0); add_word(K_WE); add_word(K_NI);
        // nmi edge over firq over irq
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 0, 0, 0, 8'h00);
        add_word(K_PC); add_word(K_CC); add_word(K_I | K_F); add_word(K_JMP | V_NMI);
        add_word(K_NI);
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 1, 0, 0, 8'h00);
        add_word(K_PC); add_word(K_CC); add_word(K_I | K_F); add_word(K_JMP | V_FIRQ);
        add_word(K_NI);
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 1, 1, 0, 8'h00);
        add_word(K_PC); add_word(K_CC); add_word(K_I); add_word(K_JMP | V_IRQ);
        add_word(K_NI);
        // masked requests fall through to the opcode
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 1, 0, 0, 8'h50);
        add_word(K_NI);
        new_entry(0, 0, ucode_pkg::NOP, 8'h00, 1, 1, 0, 8'h10);
        add_word(K_NI);
        new_entry(0, 0, ucode_pkg::ADDA_IMM, 8'h00, 1, 0, 1, 8'h40);
        add_word(K_OPD | K_UP); add_word(K_NI);
        new_entry(0, 0, 8'h01, 8'h00, 1, 1, 1, 8'h00);  // unknown opcode
        add_halt();
        new_entry(1, 0, ucode_pkg::LDA_IDX, 8'h85, 1, 1, 1, 8'h00);
        add_word(K_I | K_F | V_RST); add_word(K_NI | V_RST);
        new_entry(0, 1, ucode_pkg::LDA_IDX, 8'h85, 1, 1, 1, 8'h00);  // illegal postbyte
        add_word(K_OPD); add_halt();
        new_entry(1, 0, ucode_pkg::NOP, 8'h00, 1, 1, 1, 8'h00);
        add_word(K_I | K_F | V_RST); add_word(K_NI | V_RST);
    endtask

    task automatic apply_inputs(input int e);
        op     = e_op[e];
        mdata  = e_md[e];
        nmi_n  = e_nmi[e];
        firq_n = e_firq[e];
        irq_n  = e_irq[e];
        cc     = e_cc[e];
    endtask

    // compare each word of an entry, with random mem_busy stretches
    task automatic run_words(input int e);
        int i;
        int busy;
        logic [17:0] exp;
        i = 0;
        busy = 0;
        while (i < e_len[e]) begin
            exp = exp_w[e_first[e] + i];
            check(observed(), exp, $sformatf("entry %0d word %0d", e, i));
            // indirect request seen on the first word after the mode routine
            if ((exp & K_POST) != 0)
                check(idx_ind_rq, e_md[e][3], $sformatf("idx_ind_rq entry %0d", e));
            if (busy == 0 && i < e_len[e] - 1 && (exp & K_POST) == 0 && $urandom % 3 == 0)
                busy = 1 + $urandom % 3;
            if (busy > 0) begin
                mem_busy = 1'b1;
                busy--;
            end else begin
                mem_busy = 1'b0;
                if (i == e_len[e] - 1) begin
                    if (e_idx[e]) begin
                        check(idx_rsel, e_md[e][6:4], "idx_rsel");
                        check(idx_ind_rq, 1'b0, "idx_ind_rq after the routine");
                    end
                    if (e + 1 < n_ent && !e_reset[e + 1])
                        apply_inputs(e + 1);  // sampled during the idle slot
                end
                i++;
            end
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        logic exp_srv;
        seed_val = $urandom(63511);
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        mem_busy = 1'b0;
        op = ucode_pkg::NOP;
        mdata = 8'h00;
        cc = 8'h00;
        irq_n = 1'b1;
        firq_n = 1'b1;
        nmi_n = 1'b1;
        build_table();
        limit = n_ent * 40;
        for (int e = 0; e < n_ent; e++) begin
            if (e_reset[e]) begin
                apply_inputs(e);
                rst = 1'b1;
                repeat (4) @(posedge clk);
                #10;
                rst = 1'b0;
            end else begin
                exp_srv = (~e_nmi[e] & e_nmi[e - 1])
                        | (~e_firq[e] & ~e_cc[e][ucode_pkg::CC_F])
                        | (~e_irq[e] & ~e_cc[e][ucode_pkg::CC_I]);
                check(observed(), 18'h0, $sformatf("idle slot before entry %0d", e));
                check(intsrv, exp_srv, $sformatf("intsrv before entry %0d", e));
                @(posedge clk);
                #10;
            end
            run_words(e);
        end
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/ucode_pkg.sv
rtl/op_category.sv
rtl/idx_mode_decode.sv
rtl/int_arbiter.sv
rtl/ucode_rom.sv
rtl/ucode_seq.sv
rtl/ucode_top.sv
testbench/tb_ucode.sv

//--- Bender.yml
package:
  name: ucode_seq

sources:
  - rtl/ucode_pkg.sv
  - rtl/op_category.sv
  - rtl/idx_mode_decode.sv
  - rtl/int_arbiter.sv
  - rtl/ucode_rom.sv
  - rtl/ucode_seq.sv
  - rtl/ucode_top.sv
  - target: test
    files:
      - testbench/tb_ucode.sv
